/* build.f */
icache_pkg.sv
icache_tag_lookup.sv
icache_fill_ctrl.sv
icache_response.sv
icache_top.sv
tb_icache_checker.sv
tb_icache_top.sv

/* icache_fill_ctrl.sv */
`timescale 1ns/100ps

module icache_fill_ctrl import icache_pkg::*; (
    input  logic clk_gp_100mhz,
    input  logic rst_n,
    // Core fetch bus, Wishbone classic slave side
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  icache_addr_u cpu_adr,
    // Tag lookup
    input  logic lookup_hit,
    output icache_addr_u lookup_adr,
    output logic tag_write,
    output logic flush_line,
    output logic [INDEX_W-1:0] flush_index,
    output logic inval_line,
    // ROM bus, Wishbone classic master side
    input  logic rom_ack,
    output logic rom_cyc,
    output logic rom_stb,
    output icache_addr_u rom_adr,
    // Control pulses
    input  logic cache_flush,
    input  logic cache_invalidate,
    output logic cache_ready,
    // Data store and response
    output logic fill_we,
    output icache_addr_u fill_adr,
    output logic read_en,
    output icache_addr_u read_adr,
    output logic respond,
    output logic respond_hit,
    output logic count_hit,
    output logic count_miss
);

    // --------------------------------------------------
    // State and counters
    // --------------------------------------------------
    logic [STATE_W-1:0] state;
    // Word within the line being filled
    logic [OFFSET_W-1:0] word_cnt;
    // Line being cleared during flush
    logic [INDEX_W-1:0] flush_cnt;
    // Request address, held for the whole access
    icache_addr_u req_adr;

    // Idle accept decode, flush wins over invalidate over fetch
    logic in_idle;
    logic take_flush;
    logic take_inval;
    logic take_fetch;

    // Last word of the burst acknowledged
    logic fill_last;

    assign in_idle = (state == ST_IDLE);
    assign take_flush = in_idle && cache_flush;
    assign take_inval = in_idle && !cache_flush && cache_invalidate;
    assign take_fetch = in_idle && !cache_flush && !cache_invalidate && cpu_cyc && cpu_stb;

    assign fill_last = rom_ack && (word_cnt == OFFSET_W'(WORDS_PER_LINE - 1));

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clk_gp_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            word_cnt <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_flush) begin
                        state <= ST_FLUSH;
                        flush_cnt <= '0;
                    end else if (take_inval) begin
                        state <= ST_INVAL;
                    end else if (take_fetch) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    // Miss starts the burst at the line base
                    if (lookup_hit) begin
                        state <= ST_RESPOND;
                    end else begin
                        state <= ST_FILL;
                        word_cnt <= '0;
                    end
                end
                ST_FILL: begin
                    // Late ack just stretches this state
                    if (rom_ack) begin
                        word_cnt <= word_cnt + OFFSET_W'(1);
                    end
                    if (fill_last) begin
                        state <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    state <= ST_RESPOND;
                end
                ST_RESPOND: begin
                    // Ack is out this cycle, core still holds stb
                    state <= cpu_stb ? ST_WAIT_DROP : ST_IDLE;
                end
                ST_FLUSH: begin
                    if (flush_cnt == INDEX_W'(LINES - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        flush_cnt <= flush_cnt + INDEX_W'(1);
                    end
                end
                ST_INVAL: begin
                    state <= ST_IDLE;
                end
                ST_WAIT_DROP: begin
                    if (!cpu_stb) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request capture on fetch accept
    always_ff @(posedge clk_gp_100mhz) begin
        if (take_fetch) begin
            req_adr <= cpu_adr;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign lookup_adr = req_adr;
    assign cache_ready = in_idle;

    // ROM burst, cyc high for all 8 words
    assign rom_cyc = (state == ST_FILL);
    assign rom_stb = (state == ST_FILL);
    assign rom_adr = {req_adr.fields.tag, req_adr.fields.index, word_cnt};

    // Each word written on its own ack
    assign fill_we = (state == ST_FILL) && rom_ack;
    assign fill_adr = rom_adr;

    // Tag and valid go in once the line is complete
    assign tag_write = (state == ST_REFILL);

    // Read issued on a lookup hit or after the refill
    assign read_en = ((state == ST_LOOKUP) && lookup_hit) || (state == ST_REFILL);
    assign read_adr = req_adr;
    assign respond = read_en;
    assign respond_hit = (state == ST_LOOKUP);

    // Miss counted at the failed lookup only
    assign count_hit = (state == ST_LOOKUP) && lookup_hit;
    assign count_miss = (state == ST_LOOKUP) && !lookup_hit;

    assign flush_line = (state == ST_FLUSH);
    assign flush_index = flush_cnt;
    // Cleared at the accepting edge, while invalidate_adr is still valid
    assign inval_line = take_inval;

endmodule

/* icache_pkg.sv */
package icache_pkg;

    // --------------------------------------------------
    // Cache geometry
    // --------------------------------------------------

    // Instruction address and word width of the 16-bit core
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // Address split: tag | index | offset
    localparam int TAG_W = 5;
    localparam int INDEX_W = 8;
    localparam int OFFSET_W = 3;

    // 256 lines of 8 words, direct mapped
    localparam int LINES = 256;
    localparam int WORDS_PER_LINE = 8;

    // Hit and miss counter width
    localparam int COUNT_W = 32;

    // --------------------------------------------------
    // Sequencer state encoding
    // --------------------------------------------------
    localparam int STATE_W = 3;

    localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
    localparam logic [STATE_W-1:0] ST_LOOKUP = 3'd1;
    localparam logic [STATE_W-1:0] ST_FILL = 3'd2;
    localparam logic [STATE_W-1:0] ST_REFILL = 3'd3;
    localparam logic [STATE_W-1:0] ST_RESPOND = 3'd4;
    localparam logic [STATE_W-1:0] ST_FLUSH = 3'd5;
    localparam logic [STATE_W-1:0] ST_INVAL = 3'd6;
    localparam logic [STATE_W-1:0] ST_WAIT_DROP = 3'd7;

    // --------------------------------------------------
    // Address views
    // --------------------------------------------------

    // Tag on top, offset in the low bits
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [INDEX_W-1:0] index;
        logic [OFFSET_W-1:0] offset;
    } icache_addr_fields_t;

    // Same 16 bits, seen flat or split
    typedef union packed {
        logic [ADDR_W-1:0] word;
        icache_addr_fields_t fields;
    } icache_addr_u;

endpackage

/* icache_response.sv */
`timescale 1ns/100ps

module icache_response import icache_pkg::*; (
    input  logic clk_gp_100mhz,
    input  logic rst_n,
    // Fill write port, one word per ROM ack
    input  logic fill_we,
    input  icache_addr_u fill_adr,
    input  logic [DATA_W-1:0] rom_dat,
    // Registered read of the requested word
    input  logic read_en,
    input  icache_addr_u read_adr,
    // Acknowledge request from the sequencer
    input  logic respond,
    input  logic respond_hit,
    // Counter strobes
    input  logic count_hit,
    input  logic count_miss,
    // Core side
    output logic [DATA_W-1:0] cpu_dat,
    output logic cpu_ack,
    output logic cpu_hit,
    // Performance counters
    output logic [COUNT_W-1:0] hit_count,
    output logic [COUNT_W-1:0] miss_count
);

    // --------------------------------------------------
    // Data store
    // --------------------------------------------------

    // 2048 words, addressed by index and offset
    logic [DATA_W-1:0] data_mem [LINES*WORDS_PER_LINE];

    // Flat word addresses into the store
    logic [INDEX_W+OFFSET_W-1:0] wr_word;
    logic [INDEX_W+OFFSET_W-1:0] rd_word;

    // Tag bits do not select a word
    assign wr_word = {fill_adr.fields.index, fill_adr.fields.offset};
    assign rd_word = {read_adr.fields.index, read_adr.fields.offset};

    always_ff @(posedge clk_gp_100mhz) begin
        if (fill_we) begin
            data_mem[wr_word] <= rom_dat;
        end
    end

    // One-cycle read latency, data lands with the ack
    always_ff @(posedge clk_gp_100mhz) begin
        if (read_en) begin
            cpu_dat <= data_mem[rd_word];
        end
    end

    // --------------------------------------------------
    // Acknowledge
    // --------------------------------------------------

    // Single-cycle ack since respond is a one-cycle strobe
    always_ff @(posedge clk_gp_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            cpu_ack <= 1'b0;
            cpu_hit <= 1'b0;
        end else begin
            cpu_ack <= respond;
            if (respond) begin
                cpu_hit <= respond_hit;
            end
        end
    end

    // --------------------------------------------------
    // Hit and miss counters
    // --------------------------------------------------
    always_ff @(posedge clk_gp_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            hit_count <= '0;
            miss_count <= '0;
        end else begin
            if (count_hit) begin
                hit_count <= hit_count + COUNT_W'(1);
            end
            if (count_miss) begin
                miss_count <= miss_count + COUNT_W'(1);
            end
        end
    end

endmodule

/* icache_tag_lookup.sv */
`timescale 1ns/100ps

module icache_tag_lookup import icache_pkg::*; (
    input  logic clk_gp_100mhz,
    input  logic rst_n,
    // Latched request address from the sequencer
    input  icache_addr_u lookup_adr,
    // Line fill complete, store the tag and mark valid
    input  logic tag_write,
    // Flush walks one line per cycle
    input  logic flush_line,
    input  logic [INDEX_W-1:0] flush_index,
    // Single-line invalidate
    input  logic inval_line,
    input  icache_addr_u invalidate_adr,
    output logic lookup_hit
);

    // --------------------------------------------------
    // Tag and valid storage
    // --------------------------------------------------

    // One tag per line, qualified by its valid bit
    logic [TAG_W-1:0] tag_mem [LINES];
    logic [LINES-1:0] line_valid;

    // Index of the line being looked up
    logic [INDEX_W-1:0] lookup_index;

    assign lookup_index = lookup_adr.fields.index;

    // Combinational compare on the registered arrays
    assign lookup_hit = line_valid[lookup_index] &&
                        (tag_mem[lookup_index] == lookup_adr.fields.tag);

    // Tag write at end of fill
    always_ff @(posedge clk_gp_100mhz) begin
        if (tag_write) begin
            tag_mem[lookup_index] <= lookup_adr.fields.tag;
        end
    end

    // --------------------------------------------------
    // Valid bits
    // --------------------------------------------------
    always_ff @(posedge clk_gp_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else begin
            // Fill and clear never overlap, sequencer is in one state
            if (tag_write) begin
                line_valid[lookup_index] <= 1'b1;
            end
            if (flush_line) begin
                line_valid[flush_index] <= 1'b0;
            end
            // Index decoded straight from the invalidate address
            if (inval_line) begin
                line_valid[invalidate_adr.fields.index] <= 1'b0;
            end
        end
    end

endmodule

/* icache_top.sv */
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
    input  logic clk_gp_100mhz,
    input  logic rst_n,
    // Core fetch bus, cache is slave
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  logic [ADDR_W-1:0] cpu_adr,
    output logic [DATA_W-1:0] cpu_dat,
    output logic cpu_ack,
    output logic cpu_hit,
    // ROM bus, cache is master
    output logic rom_cyc,
    output logic rom_stb,
    output logic [ADDR_W-1:0] rom_adr,
    input  logic [DATA_W-1:0] rom_dat,
    input  logic rom_ack,
    // Line maintenance
    input  logic cache_flush,
    input  logic cache_invalidate,
    input  logic [ADDR_W-1:0] invalidate_adr,
    output logic cache_ready,
    // Performance counters
    output logic [COUNT_W-1:0] hit_count,
    output logic [COUNT_W-1:0] miss_count
);

    // --------------------------------------------------
    // Address views of the flat ports
    // --------------------------------------------------
    icache_addr_u cpu_adr_u;
    icache_addr_u inval_adr_u;
    icache_addr_u rom_adr_u;

    assign cpu_adr_u.word = cpu_adr;
    assign inval_adr_u.word = invalidate_adr;
    assign rom_adr = rom_adr_u.word;

    // Stage to stage wiring
    icache_addr_u lookup_adr;
    icache_addr_u fill_adr;
    icache_addr_u read_adr;
    logic lookup_hit;
    logic tag_write;
    logic flush_line;
    logic [INDEX_W-1:0] flush_index;
    logic inval_line;
    logic fill_we;
    logic read_en;
    logic respond;
    logic respond_hit;
    logic count_hit;
    logic count_miss;

    // --------------------------------------------------
    // Decode stage
    // --------------------------------------------------
    icache_tag_lookup tag_lookup_i (
        .clk_gp_100mhz  (clk_gp_100mhz),
        .rst_n          (rst_n),
        .lookup_adr     (lookup_adr),
        .tag_write      (tag_write),
        .flush_line     (flush_line),
        .flush_index    (flush_index),
        .inval_line     (inval_line),
        .invalidate_adr (inval_adr_u),
        .lookup_hit     (lookup_hit)
    );

    // Execute stage, fill and control sequencer
    icache_fill_ctrl fill_ctrl_i (
        .clk_gp_100mhz    (clk_gp_100mhz),
        .rst_n            (rst_n),
        .cpu_cyc          (cpu_cyc),
        .cpu_stb          (cpu_stb),
        .cpu_adr          (cpu_adr_u),
        .lookup_hit       (lookup_hit),
        .lookup_adr       (lookup_adr),
        .tag_write        (tag_write),
        .flush_line       (flush_line),
        .flush_index      (flush_index),
        .inval_line       (inval_line),
        .rom_ack          (rom_ack),
        .rom_cyc          (rom_cyc),
        .rom_stb          (rom_stb),
        .rom_adr          (rom_adr_u),
        .cache_flush      (cache_flush),
        .cache_invalidate (cache_invalidate),
        .cache_ready      (cache_ready),
        .fill_we          (fill_we),
        .fill_adr         (fill_adr),
        .read_en          (read_en),
        .read_adr         (read_adr),
        .respond          (respond),
        .respond_hit      (respond_hit),
        .count_hit        (count_hit),
        .count_miss       (count_miss)
    );

    // Result stage, data store and core response
    icache_response response_i (
        .clk_gp_100mhz (clk_gp_100mhz),
        .rst_n         (rst_n),
        .fill_we       (fill_we),
        .fill_adr      (fill_adr),
        .rom_dat       (rom_dat),
        .read_en       (read_en),
        .read_adr      (read_adr),
        .respond       (respond),
        .respond_hit   (respond_hit),
        .count_hit     (count_hit),
        .count_miss    (count_miss),
        .cpu_dat       (cpu_dat),
        .cpu_ack       (cpu_ack),
        .cpu_hit       (cpu_hit),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the icache testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps -f build.f \
    --top-module tb_icache_top -o sim_icache \
    && ./obj_dir/sim_icache > sim.log 2>&1 \
    || { echo "Verilator build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

# Pass only when the log holds the pass line
grep -qx "All checks passed" sim.log && exit 0 || exit 1

/* tb_icache_checker.sv */
`timescale 1ns/100ps

module tb_icache_checker import icache_pkg::*; (
    input  logic clk_gp_100mhz,
    input  logic rst_n,
    input  logic [3:0] test_id,
    // Core fetch bus
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  logic [ADDR_W-1:0] cpu_adr,
    input  logic [DATA_W-1:0] cpu_dat,
    input  logic cpu_ack,
    input  logic cpu_hit,
    // ROM bus
    input  logic rom_cyc,
    input  logic rom_stb,
    input  logic [ADDR_W-1:0] rom_adr,
    input  logic rom_ack,
    // Maintenance and counters
    input  logic cache_flush,
    input  logic cache_invalidate,
    input  logic [ADDR_W-1:0] invalidate_adr,
    input  logic cache_ready,
    input  logic [COUNT_W-1:0] hit_count,
    input  logic [COUNT_W-1:0] miss_count,
    output int error_count,
    output int check_count
);

    // --------------------------------------------------
    // Shadow tag model
    // --------------------------------------------------
    logic [TAG_W-1:0] sh_tag [LINES];
    logic [LINES-1:0] sh_valid;
    logic [COUNT_W-1:0] exp_hits;
    logic [COUNT_W-1:0] exp_misses;

    // Fetch in flight
    logic pending;
    logic prev_ack;
    logic exp_hit;
    icache_addr_u req;
    icache_addr_u exp_rom;
    icache_addr_u inval_view;
    int lat;
    int rom_beats;

    // Ready-low run after a flush or an invalidate
    logic busy_run;
    int low_cycles;
    int low_expected;

    // ROM contents are the inverted address XOR 5A3C
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] adr);
        return ~adr ^ 16'h5A3C;
    endfunction

    function automatic string test_label(input logic [3:0] id);
        case (id)
            4'd1: return "cold_miss_hit";
            4'd2: return "line_fill";
            4'd3: return "conflict";
            4'd4: return "inval_flush";
            4'd5: return "random_fetch";
            default: return "reset";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %0s %0s: expected %h, actual %h",
                     test_label(test_id), what, expected, actual);
        end
    endtask

    task automatic protocol_error(input string what);
        error_count++;
        $display("Protocol error in %0s: %0s", test_label(test_id), what);
    endtask

    // --------------------------------------------------
    // Sampled at the falling edge when all signals are settled
    // --------------------------------------------------
    always @(negedge clk_gp_100mhz) begin
        if (!rst_n) begin
            error_count = 0;
            check_count = 0;
            sh_valid = '0;
            exp_hits = '0;
            exp_misses = '0;
            pending = 1'b0;
            prev_ack = 1'b0;
            busy_run = 1'b0;
            lat = 0;
            rom_beats = 0;
            req.word = '0;
        end else begin
            // Flush beats invalidate when both are up
            if (cache_ready && cache_flush) begin
                sh_valid = '0;
                busy_run = 1'b1;
                low_cycles = 0;
                low_expected = LINES;
            end else if (cache_ready && cache_invalidate) begin
                inval_view.word = invalidate_adr;
                sh_valid[inval_view.fields.index] = 1'b0;
                busy_run = 1'b1;
                low_cycles = 0;
                low_expected = 1;
            end else if (busy_run) begin
                if (!cache_ready) begin
                    low_cycles++;
                end else begin
                    check_value("ready low cycles", 32'(low_expected), 32'(low_cycles));
                    busy_run = 1'b0;
                end
            end

            // Request taken at the coming edge
            if (!pending && cache_ready && cpu_cyc && cpu_stb && !cache_flush &&
                !cache_invalidate) begin
                pending = 1'b1;
                req.word = cpu_adr;
                lat = 0;
                rom_beats = 0;
            end else if (pending) begin
                lat++;
            end

            // Cyc and stb stay up from the first ack to the last
            if (pending && rom_beats > 0 && rom_beats < WORDS_PER_LINE &&
                !(rom_cyc && rom_stb)) begin
                protocol_error("ROM cyc or stb dropped inside a line burst");
            end
            if (!pending && (rom_cyc || rom_stb)) begin
                protocol_error("ROM cyc or stb high with no fetch in flight");
            end

            // Burst must walk the line upward from word 0
            if (rom_cyc && rom_stb && rom_ack) begin
                if (!pending) begin
                    protocol_error("ROM transfer with no fetch in flight");
                end
                exp_rom.word = req.word;
                exp_rom.fields.offset = OFFSET_W'(rom_beats);
                check_value("rom address", 32'(exp_rom.word), 32'(rom_adr));
                rom_beats++;
            end

            if (cpu_ack && prev_ack) begin
                protocol_error("cpu_ack high for more than one cycle");
            end
            if (cpu_ack && !pending) begin
                protocol_error("cpu_ack with no fetch in flight");
            end else if (cpu_ack) begin
                exp_hit = sh_valid[req.fields.index] &&
                          (sh_tag[req.fields.index] == req.fields.tag);
                check_value("hit flag", 32'(exp_hit), 32'(cpu_hit));
                check_value("fetch data", 32'(expected_word(req.word)), 32'(cpu_dat));
                if (exp_hit) begin
                    // Hit answers two edges after the request
                    check_value("hit latency", 32'd2, 32'(lat));
                    check_value("rom beats", 32'd0, 32'(rom_beats));
                    exp_hits = exp_hits + 1;
                end else begin
                    check_value("rom beats", 32'(WORDS_PER_LINE), 32'(rom_beats));
                    sh_valid[req.fields.index] = 1'b1;
                    sh_tag[req.fields.index] = req.fields.tag;
                    exp_misses = exp_misses + 1;
                end
                // Counters already stepped at the lookup
                check_value("hit counter", exp_hits, hit_count);
                check_value("miss counter", exp_misses, miss_count);
                pending = 1'b0;
            end
            prev_ack = cpu_ack;
        end
    end

endmodule

/* tb_icache_top.sv */
`timescale 1ns/100ps

module tb_icache_top import icache_pkg::*;;

    localparam int SEED = 665;
    localparam int CLK_PERIOD_NS = 10;
    localparam int ROM_MAX_WAIT = 3;
    localparam int DIRECTED_FETCHES = 16;
    localparam int RANDOM_FETCHES = 400;
    // Worst fill is 8 words of wait, ack and step plus lookup and response
    localparam int FETCH_WORST_CYCLES = WORDS_PER_LINE * (ROM_MAX_WAIT + 2) + 10;
    localparam int TIMEOUT_NS = ((DIRECTED_FETCHES + RANDOM_FETCHES) * FETCH_WORST_CYCLES
                                 + 2 * LINES + 1000) * CLK_PERIOD_NS;

    // Line 0x46 tag 2, its conflict partner, and an unrelated line
    localparam logic [ADDR_W-1:0] ADR_A = 16'h1234;
    localparam logic [ADDR_W-1:0] ADR_C = 16'h9234;
    localparam logic [ADDR_W-1:0] ADR_B = 16'h0840;

    logic clk_gp_100mhz;
    logic rst_n;
    logic cpu_cyc;
    logic cpu_stb;
    logic [ADDR_W-1:0] cpu_adr;
    logic [DATA_W-1:0] cpu_dat;
    logic cpu_ack;
    logic cpu_hit;
    logic rom_cyc;
    logic rom_stb;
    logic [ADDR_W-1:0] rom_adr;
    logic [DATA_W-1:0] rom_dat;
    logic rom_ack;
    logic cache_flush;
    logic cache_invalidate;
    logic [ADDR_W-1:0] invalidate_adr;
    logic cache_ready;
    logic [COUNT_W-1:0] hit_count;
    logic [COUNT_W-1:0] miss_count;
    logic [3:0] test_id;
    int error_count;
    int check_count;

    icache_top dut_i (
        .clk_gp_100mhz    (clk_gp_100mhz),
        .rst_n            (rst_n),
        .cpu_cyc          (cpu_cyc),
        .cpu_stb          (cpu_stb),
        .cpu_adr          (cpu_adr),
        .cpu_dat          (cpu_dat),
        .cpu_ack          (cpu_ack),
        .cpu_hit          (cpu_hit),
        .rom_cyc          (rom_cyc),
        .rom_stb          (rom_stb),
        .rom_adr          (rom_adr),
        .rom_dat          (rom_dat),
        .rom_ack          (rom_ack),
        .cache_flush      (cache_flush),
        .cache_invalidate (cache_invalidate),
        .invalidate_adr   (invalidate_adr),
        .cache_ready      (cache_ready),
        .hit_count        (hit_count),
        .miss_count       (miss_count)
    );

    tb_icache_checker checker_i (
        .clk_gp_100mhz    (clk_gp_100mhz),
        .rst_n            (rst_n),
        .test_id          (test_id),
        .cpu_cyc          (cpu_cyc),
        .cpu_stb          (cpu_stb),
        .cpu_adr          (cpu_adr),
        .cpu_dat          (cpu_dat),
        .cpu_ack          (cpu_ack),
        .cpu_hit          (cpu_hit),
        .rom_cyc          (rom_cyc),
        .rom_stb          (rom_stb),
        .rom_adr          (rom_adr),
        .rom_ack          (rom_ack),
        .cache_flush      (cache_flush),
        .cache_invalidate (cache_invalidate),
        .invalidate_adr   (invalidate_adr),
        .cache_ready      (cache_ready),
        .hit_count        (hit_count),
        .miss_count       (miss_count),
        .error_count      (error_count),
        .check_count      (check_count)
    );

    // --------------------------------------------------
    // Clock and ROM model
    // --------------------------------------------------
    initial begin
        clk_gp_100mhz = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_gp_100mhz = ~clk_gp_100mhz;
    end

    function automatic logic [DATA_W-1:0] rom_word(input logic [ADDR_W-1:0] adr);
        return ~adr ^ 16'h5A3C;
    endfunction

    // Each transfer acked for one cycle after 0 to 3 idle cycles
    initial begin
        int wait_left;
        wait_left = -1;
        rom_ack = 1'b0;
        rom_dat = '0;
        forever begin
            @(posedge clk_gp_100mhz);
            #1;
            rom_ack = 1'b0;
            if (rom_cyc && rom_stb) begin
                if (wait_left < 0) begin
                    wait_left = int'($urandom_range(ROM_MAX_WAIT, 0));
                end
                if (wait_left == 0) begin
                    rom_ack = 1'b1;
                    rom_dat = rom_word(rom_adr);
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // --------------------------------------------------
    // Bus tasks
    // --------------------------------------------------
    task automatic fetch(input logic [ADDR_W-1:0] adr);
        @(posedge clk_gp_100mhz);
        #1;
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_adr = adr;
        @(negedge clk_gp_100mhz);
        while (!cpu_ack) begin
            @(negedge clk_gp_100mhz);
        end
        // Ack taken at the next edge, then release
        @(posedge clk_gp_100mhz);
        #1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk_gp_100mhz);
        #1;
        while (!cache_ready) begin
            @(posedge clk_gp_100mhz);
            #1;
        end
    endtask

    task automatic flush_all();
        wait_idle();
        cache_flush = 1'b1;
        @(posedge clk_gp_100mhz);
        #1;
        cache_flush = 1'b0;
        wait_idle();
    endtask

    task automatic invalidate_line(input logic [ADDR_W-1:0] adr);
        wait_idle();
        cache_invalidate = 1'b1;
        invalidate_adr = adr;
        @(posedge clk_gp_100mhz);
        #1;
        cache_invalidate = 1'b0;
        wait_idle();
    endtask

    // 4 tags over lines 0 to 3, any word, so lines conflict often
    function automatic logic [ADDR_W-1:0] random_window_adr();
        logic [31:0] r;
        icache_addr_u a;
        r = $urandom;
        a.fields.tag = TAG_W'(r[1:0]);
        a.fields.index = INDEX_W'(r[3:2]);
        a.fields.offset = r[6:4];
        return a.word;
    endfunction

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_adr = '0;
        cache_flush = 1'b0;
        cache_invalidate = 1'b0;
        invalidate_adr = '0;
        test_id = 4'd0;
        repeat (8) @(posedge clk_gp_100mhz);
        #1;
        rst_n = 1'b1;

        test_id = 4'd1;
        fetch(ADR_A);
        fetch(ADR_A);

        // First word misses, the other seven hit
        test_id = 4'd2;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            fetch(ADR_B + ADDR_W'(i));
        end

        // Same index, other tag, evicts both ways
        test_id = 4'd3;
        fetch(ADR_C);
        fetch(ADR_A);

        test_id = 4'd4;
        invalidate_line(ADR_A);
        fetch(ADR_A);
        fetch(ADR_B);
        flush_all();
        fetch(ADR_A);
        fetch(ADR_B);

        test_id = 4'd5;
        repeat (RANDOM_FETCHES) begin
            fetch(random_window_adr());
        end

        @(posedge clk_gp_100mhz);
        $display("Closing: %0d checks, %0d errors, hit_count %0d, miss_count %0d",
                 check_count, error_count, hit_count, miss_count);
        if (error_count == 0 && check_count > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the fetch count and two flushes
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run still busy after %0d ns, a fetch or flush never finished",
                 TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule
